//--- filelist.f
+incdir+design
design/sysBusPkg.sv
design/sysCtrlPkg.sv
design/sysRegFile.sv
design/resetPulseGen.sv
design/rebootTrigger.sv
design/sysCtrlTop.sv
bench/sysCtrlChecker.sv
bench/sysCtrlTb.sv

//--- Bender.yml
package:
  name: sys_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/sysBusPkg.sv
      - design/sysCtrlPkg.sv
      - design/sysRegFile.sv
      - design/resetPulseGen.sv
      - design/rebootTrigger.sv
      - design/sysCtrlTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/sysCtrlChecker.sv
      - bench/sysCtrlTb.sv

//--- bench/sysCtrlTb.sv
`timescale 1ns/1ns

`include "sysRegs_macros.svh"

module sysCtrlTb;

    localparam logic [15:0] VersionStrap = 16'h0312;
    localparam logic [15:0] TypeStrap    = 16'h00A7;
    localparam logic [8:0]  IdCodeStrap  = 9'h15B;

    typedef enum logic [2:0] {
        OP_READ,
        OP_CS_LOW,
        OP_WRITE,
        OP_QUIET,
        OP_RESET_PULSE,
        OP_REBOOT_PULSE
    } testOp_e;

    typedef struct packed {
        testOp_e              op;
        logic [12:0]          addr;
        logic [31:0]          data;
        logic [3:0]           byteWr;
        logic [31:0]          expRead;
        sysCtrlPkg::ctrlOut_t expCtrl;
    } stimEntry_t;

    logic                 busClk = 1'b0;
    logic                 clk = 1'b0;
    logic                 rs;
    sysBusPkg::busReq_t   busReq;
    sysCtrlPkg::sysId_t   sysId;
    logic [31:0]          dataOut;
    sysCtrlPkg::ctrlOut_t ctrl;
    logic                 reset;
    logic                 reboot;
    int                   passTotal;
    int                   failTotal;

    stimEntry_t           stimTable[$];
    sysCtrlPkg::ctrlOut_t modelCtrl = '0; // expected register state while the table is built.
    logic [31:0]          lcgState = 32'd80;

    always #5 busClk = ~busClk;
    always #7 clk = ~clk; // unrelated data-path clock.

    sysCtrlTop sysCtrlTop_inst (
        .busClk  (busClk),
        .clk     (clk),
        .rs      (rs),
        .busReq  (busReq),
        .sysId   (sysId),
        .dataOut (dataOut),
        .ctrl    (ctrl),
        .reset   (reset),
        .reboot  (reboot)
    );

    sysCtrlChecker sysCtrlChecker_inst (
        .clk       (clk),
        .dataOut   (dataOut),
        .ctrl      (ctrl),
        .reset     (reset),
        .reboot    (reboot),
        .passCount (passTotal),
        .failCount (failTotal)
    );

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // field placement per register and byte lane.
    function automatic sysCtrlPkg::ctrlOut_t applyFieldRules(input sysCtrlPkg::ctrlOut_t cur,
            input logic [12:0] addr, input logic [31:0] data, input logic [3:0] lanes);
        sysCtrlPkg::ctrlOut_t nxt;
        nxt = cur;
        if (addr == `SYS_SUBSYSTEM_CTRL && lanes[0]) begin
            nxt.framerEnable = data[6];
            nxt.pngenEnable  = data[7];
        end
        if (addr == `SYS_DAC_INPUT_SEL) begin
            if (lanes[0]) nxt.dac0InputSelect = data[2:0];
            if (lanes[1]) nxt.dac1InputSelect = data[10:8];
            if (lanes[2]) nxt.dac2InputSelect = data[18:16];
        end
        if (addr == `SYS_OUTPUT_SEL && lanes[0]) begin
            nxt.ch0MuxSelect = data[3:0];
            nxt.ch1MuxSelect = data[7:4];
        end
        if (addr == `SYS_REBOOT_ADDR) begin
            for (int n = 0; n < 4; n++) begin
                if (lanes[n]) nxt.rebootAddress[8*n +: 8] = data[8*n +: 8];
            end
        end
        return nxt;
    endfunction

    function automatic logic [31:0] expectedRead(input sysCtrlPkg::ctrlOut_t c,
                                                 input logic [12:0] addr);
        logic [31:0] word;
        word = 32'h0; // reboot address and holes read zero.
        if (addr == `SYS_VERSION || addr == `SYS_RESET) begin
            word[31:16] = VersionStrap;
        end else if (addr == `SYS_TYPE || addr == `SYS_IDCODE) begin
            word[24:16] = IdCodeStrap;
            word[15:0]  = TypeStrap;
        end else if (addr == `SYS_SUBSYSTEM_CTRL) begin
            word[6] = c.framerEnable;
            word[7] = c.pngenEnable;
        end else if (addr == `SYS_DAC_INPUT_SEL) begin
            word[2:0]   = c.dac0InputSelect;
            word[10:8]  = c.dac1InputSelect;
            word[18:16] = c.dac2InputSelect;
        end else if (addr == `SYS_OUTPUT_SEL) begin
            word[3:0] = c.ch0MuxSelect;
            word[7:4] = c.ch1MuxSelect;
        end
        return word;
    endfunction

    function automatic string opLabel(input testOp_e op);
        case (op)
            OP_READ:         return "read";
            OP_CS_LOW:       return "read with cs low";
            OP_WRITE:        return "write";
            OP_QUIET:        return "no pulse";
            OP_RESET_PULSE:  return "reset pulse";
            default:         return "reboot pulse";
        endcase
    endfunction

    task automatic addEntry(input testOp_e op, input logic [12:0] addr,
                            input logic [31:0] data, input logic [3:0] lanes);
        stimEntry_t entry;
        if (lanes != 4'h0) begin
            modelCtrl = applyFieldRules(modelCtrl, addr, data, lanes);
        end
        entry.op      = op;
        entry.addr    = addr;
        entry.data    = data;
        entry.byteWr  = lanes;
        entry.expRead = (op == OP_CS_LOW) ? 32'h0 : expectedRead(modelCtrl, addr);
        entry.expCtrl = modelCtrl;
        stimTable.push_back(entry);
    endtask

    // LCG data that moves at least one field reached by the lanes.
    task automatic addChangingWrite(input testOp_e op, input logic [12:0] addr,
                                    input logic [3:0] lanes);
        logic [31:0] data;
        int          tries;
        data  = lcgNext();
        tries = 0;
        while (applyFieldRules(modelCtrl, addr, data, lanes) == modelCtrl && tries < 64) begin
            data = lcgNext();
            tries++;
        end
        addEntry(op, addr, data, lanes);
    endtask

    task automatic buildTable();
        addEntry(OP_QUIET, `SYS_VERSION, 32'h0, 4'h0); // quiet after reset.
        addEntry(OP_READ, `SYS_SUBSYSTEM_CTRL, 32'h0, 4'h0);
        addEntry(OP_READ, `SYS_DAC_INPUT_SEL, 32'h0, 4'h0);
        addEntry(OP_READ, `SYS_OUTPUT_SEL, 32'h0, 4'h0);
        addEntry(OP_READ, `SYS_VERSION, 32'h0, 4'h0);
        addEntry(OP_READ, `SYS_RESET, 32'h0, 4'h0);
        addEntry(OP_READ, `SYS_TYPE, 32'h0, 4'h0);
        addEntry(OP_READ, `SYS_IDCODE, 32'h0, 4'h0);
        addEntry(OP_READ, `SYS_REBOOT_ADDR, 32'h0, 4'h0);
        addEntry(OP_READ, 13'h020, 32'h0, 4'h0);
        addEntry(OP_READ, 13'h1FFC, 32'h0, 4'h0);
        addEntry(OP_CS_LOW, `SYS_VERSION, 32'h0, 4'h0);
        addChangingWrite(OP_WRITE, `SYS_DAC_INPUT_SEL, 4'b0001);
        addChangingWrite(OP_WRITE, `SYS_DAC_INPUT_SEL, 4'b0010);
        addChangingWrite(OP_WRITE, `SYS_DAC_INPUT_SEL, 4'b0100);
        addEntry(OP_WRITE, `SYS_DAC_INPUT_SEL, lcgNext(), 4'b1000); // no field in lane 3.
        addChangingWrite(OP_WRITE, `SYS_SUBSYSTEM_CTRL, 4'b0001);
        addEntry(OP_WRITE, `SYS_SUBSYSTEM_CTRL, lcgNext(), 4'b1110);
        addChangingWrite(OP_WRITE, `SYS_OUTPUT_SEL, 4'b0001);
        addChangingWrite(OP_QUIET, `SYS_REBOOT_ADDR, 4'b0001); // low lanes never reboot.
        addChangingWrite(OP_QUIET, `SYS_REBOOT_ADDR, 4'b0010);
        addChangingWrite(OP_QUIET, `SYS_REBOOT_ADDR, 4'b0100);
        addEntry(OP_RESET_PULSE, `SYS_RESET, lcgNext(), 4'b0001);
        addEntry(OP_QUIET, `SYS_RESET, lcgNext(), 4'b1110);
        addChangingWrite(OP_REBOOT_PULSE, `SYS_REBOOT_ADDR, 4'b1000);
        addChangingWrite(OP_REBOOT_PULSE, `SYS_REBOOT_ADDR, 4'b1000);
        addEntry(OP_READ, `SYS_DAC_INPUT_SEL, 32'h0, 4'h0);
    endtask

    // returns just after the edge that samples the write.
    task automatic busWrite(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] lanes);
        @(posedge busClk);
        busReq <= {addr, data, 1'b1, lanes};
        @(posedge busClk);
        busReq.cs     <= 1'b0;
        busReq.byteWr <= 4'h0;
        @(negedge busClk);
    endtask

    task automatic busRead(input logic [12:0] addr, input logic [31:0] expVal);
        @(posedge busClk);
        busReq <= {addr, 32'h0, 1'b1, 4'h0};
        @(negedge busClk);
        sysCtrlChecker_inst.checkReadback(expVal);
        @(posedge busClk);
        busReq.cs <= 1'b0;
    endtask

    task automatic runEntry(input int num, input stimEntry_t entry);
        sysCtrlChecker_inst.startTest(num, opLabel(entry.op), entry.addr);
        case (entry.op)
            OP_READ: begin
                busRead(entry.addr, entry.expRead);
            end
            OP_CS_LOW: begin
                @(posedge busClk);
                busReq <= {entry.addr, 32'h0, 1'b0, 4'h0};
                @(negedge busClk);
                sysCtrlChecker_inst.checkReadback(entry.expRead);
            end
            OP_WRITE: begin
                busWrite(entry.addr, entry.data, entry.byteWr);
                sysCtrlChecker_inst.checkCtrl(entry.expCtrl);
                busRead(entry.addr, entry.expRead);
            end
            OP_QUIET: begin
                if (entry.byteWr != 4'h0) busWrite(entry.addr, entry.data, entry.byteWr);
                sysCtrlChecker_inst.watchQuiet(20);
                sysCtrlChecker_inst.checkCtrl(entry.expCtrl);
            end
            default: begin
                busWrite(entry.addr, entry.data, entry.byteWr);
                sysCtrlChecker_inst.measurePulse(entry.op == OP_REBOOT_PULSE);
                sysCtrlChecker_inst.checkCtrl(entry.expCtrl);
            end
        endcase
        sysCtrlChecker_inst.finishTest();
    endtask

    initial begin
        rs     = 1'b1;
        busReq = '0;
        sysId  = {VersionStrap, TypeStrap, IdCodeStrap};
        buildTable();
        repeat (10) @(posedge busClk);
        rs <= 1'b0;
        for (int i = 0; i < stimTable.size(); i++) begin
            runEntry(i, stimTable[i]);
        end
        repeat (2) @(posedge busClk);
        $display("%0d tests run, %0d ok, %0d with errors", stimTable.size(), passTotal, failTotal);
        if (failTotal == 0 && passTotal == stimTable.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/sysCtrlChecker.sv
`timescale 1ns/1ns

`include "sysRegs_macros.svh"

module sysCtrlChecker (
    input  logic                 clk,
    input  logic [31:0]          dataOut,
    input  sysCtrlPkg::ctrlOut_t ctrl,
    input  logic                 reset,
    input  logic                 reboot,
    output int                   passCount,
    output int                   failCount
);

    localparam int PulseTimeout = 50; // clk cycles before a pulse is given up on.

    int    testNum;
    int    testErrors;
    string testLabel;

    initial begin
        passCount  = 0;
        failCount  = 0;
        testErrors = 0;
    end

    // register name for the test lines.
    function automatic sysBusPkg::regSel_e regOf(input logic [12:0] addr);
        case (addr)
            `SYS_VERSION:        return sysBusPkg::REG_VERSION;
            `SYS_RESET:          return sysBusPkg::REG_RESET;
            `SYS_TYPE:           return sysBusPkg::REG_TYPE;
            `SYS_IDCODE:         return sysBusPkg::REG_IDCODE;
            `SYS_SUBSYSTEM_CTRL: return sysBusPkg::REG_SUBSYS;
            `SYS_REBOOT_ADDR:    return sysBusPkg::REG_REBOOT;
            `SYS_DAC_INPUT_SEL:  return sysBusPkg::REG_DACSEL;
            `SYS_OUTPUT_SEL:     return sysBusPkg::REG_OUTSEL;
            default:             return sysBusPkg::REG_NONE;
        endcase
    endfunction

    function automatic string regLabel(input sysBusPkg::regSel_e sel);
        case (sel)
            sysBusPkg::REG_VERSION: return "VERSION";
            sysBusPkg::REG_RESET:   return "RESET";
            sysBusPkg::REG_TYPE:    return "TYPE";
            sysBusPkg::REG_IDCODE:  return "IDCODE";
            sysBusPkg::REG_SUBSYS:  return "SUBSYSTEM_CTRL";
            sysBusPkg::REG_REBOOT:  return "REBOOT_ADDR";
            sysBusPkg::REG_DACSEL:  return "DAC_INPUT_SEL";
            sysBusPkg::REG_OUTSEL:  return "OUTPUT_SEL";
            default:                return "unmapped";
        endcase
    endfunction

    function automatic logic pulseLevel(input bit useReboot);
        return useReboot ? reboot : reset;
    endfunction

    task automatic startTest(input int num, input string opName, input logic [12:0] addr);
        testNum    = num;
        testLabel  = $sformatf("%s %s (0x%03h)", opName, regLabel(regOf(addr)), addr);
        testErrors = 0;
    endtask

    task automatic compareValue(input string sigName, input logic [63:0] expVal,
                                input logic [63:0] actVal);
        if (actVal !== expVal) begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, sigName, expVal, actVal);
            testErrors++;
        end
    endtask

    task automatic checkReadback(input logic [31:0] expVal);
        compareValue("dataOut", expVal, dataOut);
    endtask

    // field by field, so an error names the field that went wrong.
    task automatic checkCtrl(input sysCtrlPkg::ctrlOut_t expVal);
        compareValue("ctrl.rebootAddress", expVal.rebootAddress, ctrl.rebootAddress);
        compareValue("ctrl.dac0InputSelect", expVal.dac0InputSelect, ctrl.dac0InputSelect);
        compareValue("ctrl.dac1InputSelect", expVal.dac1InputSelect, ctrl.dac1InputSelect);
        compareValue("ctrl.dac2InputSelect", expVal.dac2InputSelect, ctrl.dac2InputSelect);
        compareValue("ctrl.ch0MuxSelect", expVal.ch0MuxSelect, ctrl.ch0MuxSelect);
        compareValue("ctrl.ch1MuxSelect", expVal.ch1MuxSelect, ctrl.ch1MuxSelect);
        compareValue("ctrl.pngenEnable", expVal.pngenEnable, ctrl.pngenEnable);
        compareValue("ctrl.framerEnable", expVal.framerEnable, ctrl.framerEnable);
    endtask

    // neither pulse may show up for the given number of clk cycles.
    task automatic watchQuiet(input int cycles);
        int count;
        bit stray;
        count = 0;
        stray = 1'b0;
        while (!stray && count < cycles) begin
            @(negedge clk);
            count++;
            if (reset || reboot) begin
                stray = 1'b1;
            end
        end
        if (stray) begin
            $display("An unexpected %s pulse showed up at %0t ns.",
                     reset ? "reset" : "reboot", $time);
            testErrors++;
        end
    endtask

    task automatic measurePulse(input bit useReboot);
        string pulseName;
        int    waited;
        int    width;
        bit    seen;
        pulseName = useReboot ? "reboot" : "reset";
        waited    = 0;
        seen      = 1'b0;
        while (!seen && waited < PulseTimeout) begin
            @(negedge clk);
            waited++;
            seen = pulseLevel(useReboot);
        end
        if (!seen) begin
            $display("The %s pulse never came within %0d clk cycles (%0t ns).",
                     pulseName, PulseTimeout, $time);
            testErrors++;
        end else begin
            width = 0;
            while (pulseLevel(useReboot) && width < PulseTimeout) begin
                width++; // one negedge per high clk cycle.
                @(negedge clk);
            end
            compareValue({pulseName, " width"}, useReboot ? 1 : `RESET_HOLD_CYCLES, width);
            watchQuiet(10); // a second pulse would land here.
        end
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
            $display("test %0d %s: ok", testNum, testLabel);
        end else begin
            failCount++;
            $display("test %0d %s: FAILED with %0d error(s)", testNum, testLabel, testErrors);
        end
    endtask

endmodule

//--- design/sysCtrlTop.sv
`timescale 1ns/1ns

module sysCtrlTop (
    input  logic                 busClk,
    input  logic                 clk,
    input  logic                 rs,
    input  sysBusPkg::busReq_t   busReq,
    input  sysCtrlPkg::sysId_t   sysId,
    output logic [31:0]          dataOut,
    output sysCtrlPkg::ctrlOut_t ctrl,
    output logic                 reset,
    output logic                 reboot
);

    // requests crossing from busClk to clk.
    logic resetToggle;
    logic rebootToggle;

    sysRegFile sysRegFile_inst (
        .busClk       (busClk),
        .rs           (rs),
        .busReq       (busReq),
        .sysId        (sysId),
        .dataOut      (dataOut),
        .ctrl         (ctrl),
        .resetToggle  (resetToggle),
        .rebootToggle (rebootToggle)
    );

    resetPulseGen resetPulseGen_inst (
        .clk         (clk),
        .rs          (rs),
        .resetToggle (resetToggle),
        .reset       (reset)
    );

    rebootTrigger rebootTrigger_inst (
        .clk          (clk),
        .rs           (rs),
        .rebootToggle (rebootToggle),
        .reboot       (reboot)
    );

endmodule

//--- design/rebootTrigger.sv
`timescale 1ns/1ns

`include "sysRegs_macros.svh"

module rebootTrigger (
    input  logic clk,
    input  logic rs,
    input  logic rebootToggle,
    output logic reboot
);

    logic [`SYNC_STAGES-1:0] toggleSync;
    logic                    toggleLast;
    logic                    toggleEdge;

    // one clean pulse per toggle change, all from flops.
    always_ff @(posedge clk or posedge rs) begin
        if (rs) begin
            toggleSync <= '0;
            toggleLast <= 1'b0;
            toggleEdge <= 1'b0;
            reboot     <= 1'b0;
        end else begin
            toggleSync <= {toggleSync[`SYNC_STAGES-2:0], rebootToggle};
            toggleLast <= toggleSync[`SYNC_STAGES-1];
            toggleEdge <= toggleSync[`SYNC_STAGES-1] ^ toggleLast;
            reboot     <= toggleEdge; // the flash loader sees a single cycle.
        end
    end

endmodule

//--- design/resetPulseGen.sv
`timescale 1ns/1ns

`include "sysRegs_macros.svh"

module resetPulseGen (
    input  logic clk,
    input  logic rs,
    input  logic resetToggle,
    output logic reset
);

    localparam int HoldWidth = $clog2(`RESET_HOLD_CYCLES + 1);

    logic [`SYNC_STAGES-1:0] toggleSync;
    logic                    toggleLast;
    logic                    toggleEdge;
    sysCtrlPkg::rstState_e   state;
    logic [HoldWidth-1:0]    holdCount;

    // bring the busClk toggle across and mark each change.
    always_ff @(posedge clk or posedge rs) begin
        if (rs) begin
            toggleSync <= '0;
            toggleLast <= 1'b0;
            toggleEdge <= 1'b0;
        end else begin
            toggleSync <= {toggleSync[`SYNC_STAGES-2:0], resetToggle};
            toggleLast <= toggleSync[`SYNC_STAGES-1];
            toggleEdge <= toggleSync[`SYNC_STAGES-1] ^ toggleLast;
        end
    end

    always_ff @(posedge clk or posedge rs) begin
        if (rs) begin
            state     <= sysCtrlPkg::IDLE;
            holdCount <= '0;
        end else begin
            case (state)
                sysCtrlPkg::IDLE: begin
                    if (toggleEdge) begin
                        state     <= sysCtrlPkg::HOLD;
                        holdCount <= HoldWidth'(`RESET_HOLD_CYCLES);
                    end
                end
                sysCtrlPkg::HOLD: begin
                    if (toggleEdge) begin
                        holdCount <= HoldWidth'(`RESET_HOLD_CYCLES); // restart on a new request.
                    end else if (holdCount == HoldWidth'(1)) begin
                        state     <= sysCtrlPkg::IDLE;
                        holdCount <= '0;
                    end else begin
                        holdCount <= holdCount - 1'b1;
                    end
                end
                default: begin
                    state <= sysCtrlPkg::IDLE;
                end
            endcase
        end
    end

    assign reset = (state == sysCtrlPkg::HOLD); // straight from a flop, no decode glitch.

endmodule

//--- design/sysRegFile.sv
`timescale 1ns/1ns

`include "sysRegs_macros.svh"

module sysRegFile (
    input  logic                 busClk,
    input  logic                 rs,
    input  sysBusPkg::busReq_t   busReq,
    input  sysCtrlPkg::sysId_t   sysId,
    output logic [31:0]          dataOut,
    output sysCtrlPkg::ctrlOut_t ctrl,
    output logic                 resetToggle,
    output logic                 rebootToggle
);

    sysBusPkg::regSel_e regSel;
    logic [3:0]         laneWr;

    // lane strobes only count while selected.
    assign laneWr = busReq.byteWr & {4{busReq.cs}};

    // address decode.
    always_comb begin
        case (busReq.addr)
            `SYS_VERSION:        regSel = sysBusPkg::REG_VERSION;
            `SYS_RESET:          regSel = sysBusPkg::REG_RESET;
            `SYS_TYPE:           regSel = sysBusPkg::REG_TYPE;
            `SYS_IDCODE:         regSel = sysBusPkg::REG_IDCODE;
            `SYS_SUBSYSTEM_CTRL: regSel = sysBusPkg::REG_SUBSYS;
            `SYS_REBOOT_ADDR:    regSel = sysBusPkg::REG_REBOOT;
            `SYS_DAC_INPUT_SEL:  regSel = sysBusPkg::REG_DACSEL;
            `SYS_OUTPUT_SEL:     regSel = sysBusPkg::REG_OUTSEL;
            default:             regSel = sysBusPkg::REG_NONE;
        endcase
    end

    // byte-lane writes and toggle requests.
    always_ff @(posedge busClk or posedge rs) begin
        if (rs) begin
            ctrl         <= '0;
            resetToggle  <= 1'b0;
            rebootToggle <= 1'b0;
        end else begin
            case (regSel)
                sysBusPkg::REG_RESET: begin
                    if (laneWr[0]) begin
                        resetToggle <= ~resetToggle; // picked up in the clk domain.
                    end
                end
                sysBusPkg::REG_SUBSYS: begin
                    if (laneWr[0]) begin
                        ctrl.framerEnable <= busReq.dataIn[6];
                        ctrl.pngenEnable  <= busReq.dataIn[7];
                    end
                end
                sysBusPkg::REG_REBOOT: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (laneWr[lane]) begin
                            ctrl.rebootAddress[lane*8 +: 8] <= busReq.dataIn[lane*8 +: 8];
                        end
                    end
                    // top byte completes the address and fires the reboot.
                    if (laneWr[3]) begin
                        rebootToggle <= ~rebootToggle;
                    end
                end
                sysBusPkg::REG_DACSEL: begin
                    if (laneWr[0]) begin
                        ctrl.dac0InputSelect <= busReq.dataIn[2:0];
                    end
                    if (laneWr[1]) begin
                        ctrl.dac1InputSelect <= busReq.dataIn[10:8];
                    end
                    if (laneWr[2]) begin
                        ctrl.dac2InputSelect <= busReq.dataIn[18:16];
                    end
                end
                sysBusPkg::REG_OUTSEL: begin
                    if (laneWr[0]) begin
                        ctrl.ch0MuxSelect <= busReq.dataIn[3:0];
                        ctrl.ch1MuxSelect <= busReq.dataIn[7:4];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // readback, zero latency.
    always_comb begin
        dataOut = 32'h0;
        if (busReq.cs) begin
            case (regSel)
                sysBusPkg::REG_VERSION,
                sysBusPkg::REG_RESET: begin
                    dataOut = {sysId.versionNumber, 16'h0};
                end
                sysBusPkg::REG_TYPE,
                sysBusPkg::REG_IDCODE: begin
                    dataOut = {7'h0, sysId.idCode, sysId.fpgaType};
                end
                sysBusPkg::REG_SUBSYS: begin
                    dataOut[7:6] = {ctrl.pngenEnable, ctrl.framerEnable};
                end
                sysBusPkg::REG_DACSEL: begin
                    dataOut = {13'h0, ctrl.dac2InputSelect,
                               5'h0, ctrl.dac1InputSelect,
                               5'h0, ctrl.dac0InputSelect};
                end
                sysBusPkg::REG_OUTSEL: begin
                    dataOut[7:0] = {ctrl.ch1MuxSelect, ctrl.ch0MuxSelect};
                end
                default: begin
                    dataOut = 32'h0; // reboot address is write only.
                end
            endcase
        end
    end

endmodule

//--- design/sysCtrlPkg.sv
package sysCtrlPkg;

    // control outputs toward the data path and the flash loader.
    typedef struct packed {
        logic [31:0] rebootAddress;   // start address for reconfiguration.
        logic [2:0]  dac0InputSelect;
        logic [2:0]  dac1InputSelect;
        logic [2:0]  dac2InputSelect;
        logic [3:0]  ch0MuxSelect;
        logic [3:0]  ch1MuxSelect;
        logic        pngenEnable;
        logic        framerEnable;
    } ctrlOut_t;

    // identity straps, fixed per build.
    typedef struct packed {
        logic [15:0] versionNumber;
        logic [15:0] fpgaType;
        logic [8:0]  idCode;
    } sysId_t;

    // soft reset pulse generator.
    // HOLD keeps reset asserted while the counter runs down.
    typedef enum logic {
        IDLE,
        HOLD
    } rstState_e;

endpackage

//--- design/sysBusPkg.sv
package sysBusPkg;

    // one host bus cycle as seen at the register block.
    typedef struct packed {
        logic [12:0] addr;
        logic [31:0] dataIn;
        logic        cs;     // chip select, qualifies both reads and writes.
        logic [3:0]  byteWr; // bit n enables byte lane n.
    } busReq_t;

    // register picked out of the address.
    typedef enum logic [3:0] {
        REG_NONE,
        REG_VERSION,
        REG_RESET,
        REG_TYPE,
        REG_IDCODE,
        REG_SUBSYS,
        REG_REBOOT,
        REG_DACSEL,
        REG_OUTSEL
    } regSel_e;

endpackage

//--- design/sysRegs_macros.svh
`ifndef SYS_REGS_MACROS_SVH
`define SYS_REGS_MACROS_SVH

// register offsets on the 13-bit host address.
`define SYS_VERSION          13'h000
`define SYS_RESET            13'h004
`define SYS_TYPE             13'h008
`define SYS_IDCODE           13'h00C
`define SYS_SUBSYSTEM_CTRL   13'h010
`define SYS_REBOOT_ADDR      13'h014
`define SYS_DAC_INPUT_SEL    13'h018
`define SYS_OUTPUT_SEL       13'h01C

// length of the soft reset pulse in clk cycles.
`define RESET_HOLD_CYCLES    6

// flops in each toggle synchronizer.
`define SYNC_STAGES          2

`endif
